/* include/glcd_macros.svh */
`ifndef GLCD_MACROS_SVH
`define GLCD_MACROS_SVH

// Panel geometry of the two-controller 128x64 LCD
`define GLCD_WIDTH       128  // Pixels across both halves
`define GLCD_HALF_COLS   64   // Columns driven by one chip select
`define GLCD_PAGES       8    // Eight-row pages

// Frame store contents
`define GLCD_NUM_IMAGES  2    // Images cycled on the panel

// Wait between erase or image and the next image, in enable periods
`define GLCD_IDLE_CYCLES 300

// Panel instruction codes
`define GLCD_CMD_ON         8'h3F  // Display on
`define GLCD_CMD_START_LINE 8'hC0  // Start line 0
`define GLCD_CMD_SET_PAGE   8'hB8  // Base, page number added
`define GLCD_CMD_SET_Y      8'h40  // Base, column added

`endif

/* hdl/glcd_pkg.sv */
package glcd_pkg;

  typedef logic [7:0]  byte_t;        // Panel and memory data
  typedef logic [10:0] store_addr_t;  // {image, row, byte-in-row}
  typedef logic [0:0]  image_t;       // Image index
  typedef logic [2:0]  page_t;        // Page index
  typedef logic [5:0]  col_t;         // Column within a half

  // Panel sequencing
  typedef enum logic [3:0] {
    INIT_ON,    // Display on to both halves
    INIT_LINE,  // Start line to both halves
    ERASE,      // Clear every page
    IDLE,       // Wait before the next image
    REQUEST,    // Block handshake with the transposer
    SEND_PAGE,  // Page address for the block
    SEND_Y,     // Column address 0
    SEND_DATA,  // 64 column bytes
    NEXT        // Step to the next image
  } ctrl_state_t;

endpackage

/* hdl/frame_store.sv */
`timescale 1ns/1ps
`include "glcd_macros.svh"

module frame_store (
  input  logic                  clk,
  input  logic                  load_en,
  input  glcd_pkg::store_addr_t load_addr,
  input  glcd_pkg::byte_t       load_data,
  input  glcd_pkg::store_addr_t rd_addr,
  output glcd_pkg::byte_t       rd_byte
);

  // Row-major image layout, MSB is the leftmost pixel of each byte
  localparam int ROW_BYTES = `GLCD_WIDTH / 8;
  localparam int ROWS      = `GLCD_PAGES * 8;
  localparam int DEPTH     = `GLCD_NUM_IMAGES * ROW_BYTES * ROWS;

  glcd_pkg::byte_t mem [DEPTH];  // All images back to back

  // Host side, one byte per clock
  always_ff @(posedge clk)
  begin
    if (load_en)
    begin
      mem[load_addr] <= load_data;
    end
  end

  // Read side for the block transposer, one clock of latency
  always_ff @(posedge clk)
  begin
    rd_byte <= mem[rd_addr];
  end

endmodule

/* hdl/block_transposer.sv */
`timescale 1ns/1ps
`include "glcd_macros.svh"

module block_transposer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  blk_req,
  input  glcd_pkg::image_t      blk_image,
  input  glcd_pkg::page_t       blk_page,
  input  logic                  blk_half,
  output logic                  blk_ack,
  output glcd_pkg::store_addr_t rd_addr,
  input  glcd_pkg::byte_t       rd_byte,
  input  glcd_pkg::col_t        col_sel,
  output glcd_pkg::byte_t       col_byte
);

  // One block is 8 rows of 8 bytes, which is also 64 reads
  localparam glcd_pkg::col_t LAST_READ = glcd_pkg::col_t'(`GLCD_HALF_COLS - 1);

  logic           busy;    // Issuing store reads
  glcd_pkg::col_t rd_cnt;  // {row, byte} being addressed
  logic           rd_vld;  // rd_byte carries a block byte
  glcd_pkg::col_t rd_idx;  // {row, byte} of the byte in rd_byte
  logic           start;

  glcd_pkg::byte_t cols [`GLCD_HALF_COLS];  // Transposed column bytes

  // New block only once the previous handshake has fully closed
  assign start = blk_req && !busy && !rd_vld && !blk_ack;

  // Image, row within the page, half, then byte within the half
  assign rd_addr = {blk_image, blk_page, rd_cnt[5:3], blk_half, rd_cnt[2:0]};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      rd_cnt  <= '0;
      rd_vld  <= 1'b0;
      rd_idx  <= '0;
      blk_ack <= 1'b0;
    end
    else
    begin
      rd_vld <= busy;    // Store read latency
      rd_idx <= rd_cnt;
      if (start)
      begin
        busy   <= 1'b1;
        rd_cnt <= '0;
      end
      else if (busy)
      begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_cnt == LAST_READ)
        begin
          busy <= 1'b0;
        end
      end
      // Ack once the last byte has been scattered, hold until req drops
      if (rd_vld && rd_idx == LAST_READ)
      begin
        blk_ack <= 1'b1;
      end
      else if (!blk_req)
      begin
        blk_ack <= 1'b0;
      end
    end
  end

  // Byte b of row r feeds bit r of columns b*8 .. b*8+7
  always_ff @(posedge clk)
  begin
    if (rd_vld)
    begin
      for (int i = 0; i < 8; i++)
      begin
        cols[{rd_idx[2:0], 3'(i)}][rd_idx[5:3]] <= rd_byte[7 - i];  // MSB to lowest column
      end
    end
  end

  assign col_byte = cols[col_sel];

  // Ack follows a live request, never a dropped one
  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(blk_ack) |-> blk_req
  ) else $error("blk_ack rose without blk_req");

  // The controller holds the block coordinates for the whole request
  a_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    blk_req && $past(blk_req) |-> $stable({blk_image, blk_page, blk_half})
  ) else $error("block coordinates changed during blk_req");

endmodule

/* hdl/glcd_ctrl.sv */
`timescale 1ns/1ps
`include "glcd_macros.svh"

module glcd_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run,
  output logic                  blk_req,
  output glcd_pkg::image_t      blk_image,
  output glcd_pkg::page_t       blk_page,
  output logic                  blk_half,
  input  logic                  blk_ack,
  output glcd_pkg::col_t        col_sel,
  input  glcd_pkg::byte_t       col_byte,
  output logic                  lcd_en,
  output logic                  lcd_di,
  output logic                  lcd_rw,
  output logic [1:0]            lcd_cs,
  output glcd_pkg::byte_t       lcd_data
);

  localparam int IDLE_W = $clog2(`GLCD_IDLE_CYCLES);

  localparam logic [IDLE_W-1:0] IDLE_LAST  = IDLE_W'(`GLCD_IDLE_CYCLES - 1);
  localparam glcd_pkg::page_t   PAGE_LAST  = glcd_pkg::page_t'(`GLCD_PAGES - 1);
  localparam glcd_pkg::col_t    COL_LAST   = glcd_pkg::col_t'(`GLCD_HALF_COLS - 1);
  localparam glcd_pkg::image_t  IMAGE_LAST = glcd_pkg::image_t'(`GLCD_NUM_IMAGES - 1);
  localparam logic [6:0]        ERASE_LAST = 7'(`GLCD_HALF_COLS + 1);  // Two commands, 64 bytes

  glcd_pkg::ctrl_state_t state, state_next;
  glcd_pkg::page_t       page, page_next;
  logic                  half, half_next;    // 0 left, 1 right
  glcd_pkg::col_t        col, col_next;
  glcd_pkg::image_t      image, image_next;
  logic [IDLE_W-1:0]     idle_cnt, idle_cnt_next;
  logic [6:0]            erase_step, erase_step_next;
  logic                  blk_req_next;
  logic                  lcd_di_next;
  logic [1:0]            lcd_cs_next;
  glcd_pkg::byte_t       lcd_data_next;

  assign blk_image = image;
  assign blk_page  = page;
  assign blk_half  = half;
  assign col_sel   = col;
  assign lcd_rw    = 1'b0;  // Write only

  always_comb
  begin
    state_next      = state;
    page_next       = page;
    half_next       = half;
    col_next        = col;
    image_next      = image;
    idle_cnt_next   = idle_cnt;
    erase_step_next = erase_step;
    blk_req_next    = blk_req;
    lcd_di_next     = lcd_di;
    lcd_cs_next     = lcd_cs;
    lcd_data_next   = lcd_data;
    if (!lcd_en)  // One step per enable period
    begin
      lcd_di_next   = 1'b0;  // Idle transfer unless overridden
      lcd_cs_next   = 2'b00;
      lcd_data_next = `GLCD_CMD_ON;
      case (state)
        glcd_pkg::INIT_ON:
        begin
          if (run)
          begin
            lcd_cs_next = 2'b11;
            state_next  = glcd_pkg::INIT_LINE;
          end
        end
        glcd_pkg::INIT_LINE:
        begin
          lcd_cs_next     = 2'b11;
          lcd_data_next   = `GLCD_CMD_START_LINE;
          page_next       = '0;
          erase_step_next = '0;
          state_next      = glcd_pkg::ERASE;
        end
        glcd_pkg::ERASE:
        begin
          lcd_cs_next = 2'b11;  // Both halves at once
          if (erase_step == 7'd0)
          begin
            lcd_data_next = `GLCD_CMD_SET_PAGE + {5'd0, page};
          end
          else if (erase_step == 7'd1)
          begin
            lcd_data_next = `GLCD_CMD_SET_Y;  // Column 0
          end
          else
          begin
            lcd_di_next   = 1'b1;
            lcd_data_next = '0;
          end
          if (erase_step == ERASE_LAST)
          begin
            erase_step_next = '0;
            if (page == PAGE_LAST)
            begin
              page_next     = '0;
              idle_cnt_next = '0;
              state_next    = glcd_pkg::IDLE;
            end
            else
            begin
              page_next = page + 1'b1;
            end
          end
          else
          begin
            erase_step_next = erase_step + 1'b1;
          end
        end
        glcd_pkg::IDLE:
        begin
          if (idle_cnt == IDLE_LAST)
          begin
            page_next  = '0;
            half_next  = 1'b0;
            state_next = glcd_pkg::REQUEST;
          end
          else
          begin
            idle_cnt_next = idle_cnt + 1'b1;
          end
        end
        glcd_pkg::REQUEST:
        begin
          // Raise only after the last ack has gone, drop on ack
          if (!blk_req && !blk_ack)
          begin
            blk_req_next = 1'b1;
          end
          else if (blk_req && blk_ack)
          begin
            blk_req_next = 1'b0;
            state_next   = glcd_pkg::SEND_PAGE;
          end
        end
        glcd_pkg::SEND_PAGE:
        begin
          lcd_cs_next   = {half, ~half};
          lcd_data_next = `GLCD_CMD_SET_PAGE + {5'd0, page};
          state_next    = glcd_pkg::SEND_Y;
        end
        glcd_pkg::SEND_Y:
        begin
          lcd_cs_next   = {half, ~half};
          lcd_data_next = `GLCD_CMD_SET_Y;
          col_next      = '0;
          state_next    = glcd_pkg::SEND_DATA;
        end
        glcd_pkg::SEND_DATA:
        begin
          lcd_cs_next   = {half, ~half};
          lcd_di_next   = 1'b1;
          lcd_data_next = col_byte;
          col_next      = col + 1'b1;
          if (col == COL_LAST)
          begin
            half_next  = ~half;
            state_next = glcd_pkg::REQUEST;
            if (half)  // Right half done, page complete
            begin
              if (page == PAGE_LAST)
              begin
                state_next = glcd_pkg::NEXT;
              end
              else
              begin
                page_next = page + 1'b1;
              end
            end
          end
        end
        glcd_pkg::NEXT:
        begin
          image_next    = (image == IMAGE_LAST) ? '0 : image + 1'b1;
          page_next     = '0;
          idle_cnt_next = '0;
          state_next    = glcd_pkg::IDLE;
        end
        default:
        begin
          state_next = glcd_pkg::INIT_ON;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= glcd_pkg::INIT_ON;
      page       <= '0;
      half       <= 1'b0;
      col        <= '0;
      image      <= '0;
      idle_cnt   <= '0;
      erase_step <= '0;
      blk_req    <= 1'b0;
      lcd_en     <= 1'b0;
      lcd_di     <= 1'b0;
      lcd_cs     <= 2'b00;
      lcd_data   <= `GLCD_CMD_ON;
    end
    else
    begin
      state      <= state_next;
      page       <= page_next;
      half       <= half_next;
      col        <= col_next;
      image      <= image_next;
      idle_cnt   <= idle_cnt_next;
      erase_step <= erase_step_next;
      blk_req    <= blk_req_next;
      lcd_en     <= ~lcd_en;  // Free running enable
      lcd_di     <= lcd_di_next;
      lcd_cs     <= lcd_cs_next;
      lcd_data   <= lcd_data_next;
    end
  end

  // Bus changes land as lcd_en rises, so they hold across the falling edge
  a_bus_on_low_en: assert property (
    @(posedge clk) disable iff (!rst_n)
    $changed({lcd_di, lcd_rw, lcd_cs, lcd_data}) |-> $past(lcd_en) == 1'b0
  ) else $error("panel bus changed outside the lcd_en low phase");

  // Four-phase rule, a new request waits for the old ack to fall
  a_req_after_ack: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(blk_req) |-> !$past(blk_ack)
  ) else $error("blk_req rose while blk_ack was high");

endmodule

/* hdl/glcd_display.sv */
`timescale 1ns/1ps

module glcd_display (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run,
  input  logic                  load_en,
  input  glcd_pkg::store_addr_t load_addr,
  input  glcd_pkg::byte_t       load_data,
  output logic                  lcd_en,
  output logic                  lcd_di,
  output logic                  lcd_rw,
  output logic [1:0]            lcd_cs,
  output glcd_pkg::byte_t       lcd_data
);

  glcd_pkg::store_addr_t rd_addr;
  glcd_pkg::byte_t       rd_byte;
  logic                  blk_req;
  logic                  blk_ack;
  glcd_pkg::image_t      blk_image;
  glcd_pkg::page_t       blk_page;
  logic                  blk_half;
  glcd_pkg::col_t        col_sel;
  glcd_pkg::byte_t       col_byte;

  frame_store frame_store_i (
    .clk       (clk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd_addr   (rd_addr),
    .rd_byte   (rd_byte)
  );

  block_transposer block_transposer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .blk_req   (blk_req),
    .blk_image (blk_image),
    .blk_page  (blk_page),
    .blk_half  (blk_half),
    .blk_ack   (blk_ack),
    .rd_addr   (rd_addr),
    .rd_byte   (rd_byte),
    .col_sel   (col_sel),
    .col_byte  (col_byte)
  );

  glcd_ctrl glcd_ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .blk_req   (blk_req),
    .blk_image (blk_image),
    .blk_page  (blk_page),
    .blk_half  (blk_half),
    .blk_ack   (blk_ack),
    .col_sel   (col_sel),
    .col_byte  (col_byte),
    .lcd_en    (lcd_en),
    .lcd_di    (lcd_di),
    .lcd_rw    (lcd_rw),
    .lcd_cs    (lcd_cs),
    .lcd_data  (lcd_data)
  );

endmodule

/* sim/tb_glcd_display.sv */
`timescale 1ns/1ps
`include "glcd_macros.svh"

module tb_glcd_display;

  localparam int ROW_BYTES   = `GLCD_WIDTH / 8;
  localparam int IMAGE_BYTES = ROW_BYTES * `GLCD_PAGES * 8;
  localparam int STORE_BYTES = `GLCD_NUM_IMAGES * IMAGE_BYTES;
  localparam int BLOCK_LEN   = `GLCD_HALF_COLS + 2;          // Page, Y, then data
  localparam int FIRST_SEND  = 2 + `GLCD_PAGES * BLOCK_LEN;  // After init and erase
  localparam int PASS_LEN    = `GLCD_PAGES * 2 * BLOCK_LEN;
  localparam int LOG_LEN     = FIRST_SEND + `GLCD_NUM_IMAGES * PASS_LEN + BLOCK_LEN;
  localparam int MAX_RECS    = 64;
  localparam int BLOCKS      = `GLCD_NUM_IMAGES * `GLCD_PAGES * 2 + 1;
  // Enable periods with idle waits and block handshakes
  localparam int PERIODS     = LOG_LEN + (`GLCD_NUM_IMAGES + 1) * `GLCD_IDLE_CYCLES
                               + BLOCKS * (`GLCD_HALF_COLS / 2 + 4);
  localparam int LOAD_CLOCKS = STORE_BYTES + 8 + 16;
  localparam int WATCHDOG_NS = (2 * PERIODS * 2 + LOAD_CLOCKS) * 40;

  typedef logic [255:0] text_t;
  typedef logic [10:0]  xfer_t;  // {cs, di, data}

  logic                  clk;
  logic                  rst_n;
  logic                  run;
  logic                  load_en;
  glcd_pkg::store_addr_t load_addr;
  glcd_pkg::byte_t       load_data;
  logic                  lcd_en;
  logic                  lcd_di;
  logic                  lcd_rw;
  logic [1:0]            lcd_cs;
  glcd_pkg::byte_t       lcd_data;

  glcd_pkg::byte_t image_mem [STORE_BYTES];  // Host copy of the frame store
  xfer_t           exp_log [LOG_LEN];        // Modeled write order
  xfer_t           bus_log [$];
  int              log_count;
  int              exp_count;
  text_t           rec_name [MAX_RECS];
  text_t           rec_kind [MAX_RECS];
  logic [31:0]     rec_arg [MAX_RECS];
  logic [31:0]     rec_exp [MAX_RECS];
  int              num_recs;
  logic [31:0]     lcg_state;
  logic            en_prev;   // lcd_en at the previous falling clock edge
  logic            en_armed;  // Previous sample was taken out of reset

  glcd_display glcd_display_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .lcd_en    (lcd_en),
    .lcd_di    (lcd_di),
    .lcd_rw    (lcd_rw),
    .lcd_cs    (lcd_cs),
    .lcd_data  (lcd_data)
  );

  always #20 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("Failure: %s", msg);
    $display("*** FAILED ***");
    $fatal(1, "run aborted");
  endtask

  task automatic value_error(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    $display("Error: %s expected %h actual %h", name, expected, actual);
    $display("*** FAILED ***");
    $fatal(1, "value mismatch");
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic read_tests();
    int               fd;
    int               n;
    logic [8*160-1:0] line;
    text_t            name;
    text_t            kind;
    logic [31:0]      arg;
    logic [31:0]      expected;
    fd = $fopen("sim/glcd_tests.txt", "r");
    if (fd == 0)
      abort_run("could not open sim/glcd_tests.txt");
    num_recs = 0;
    while (!$feof(fd))
    begin
      line = '0;
      name = '0;
      kind = '0;
      if ($fgets(line, fd) != 0)
      begin
        n = $sscanf(line, "%s %s %h %h", name, kind, arg, expected);
        if (n >= 1 && name != text_t'("#"))  // Comment lines start with #
        begin
          if (n != 4 || num_recs == MAX_RECS)
            abort_run("malformed or excess record in the tests file");
          rec_name[num_recs] = name;
          rec_kind[num_recs] = kind;
          rec_arg[num_recs]  = arg;
          rec_exp[num_recs]  = expected;
          num_recs++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic build_images();
    lcg_state = 32'd4;
    for (int a = 0; a < STORE_BYTES; a++)
    begin
      lcg_state    = lcg_next(lcg_state);
      image_mem[a] = lcg_state[23:16];
    end
  endtask

  // Pixel records force their column byte into image 0
  task automatic plant_pixels();
    int page;
    int half;
    int col;
    int addr;
    for (int i = 0; i < num_recs; i++)
    begin
      if (rec_kind[i] == text_t'("pixel"))
      begin
        page = int'(rec_arg[i][9:7]);
        half = int'(rec_arg[i][6]);
        col  = int'(rec_arg[i][5:0]);
        for (int r = 0; r < 8; r++)
        begin
          addr = (page * 8 + r) * ROW_BYTES + (half * `GLCD_HALF_COLS + col) / 8;
          image_mem[addr][3'(7 - col % 8)] = rec_exp[i][5'(r)];
        end
      end
    end
  endtask

  // Bit r is the pixel of row page*8+r and the MSB of a store byte is leftmost
  function automatic glcd_pkg::byte_t model_column(input int image, input int page,
                                                   input int half, input int col);
    glcd_pkg::byte_t col_bits;
    glcd_pkg::byte_t pix_byte;
    int              x;
    x = half * `GLCD_HALF_COLS + col;
    for (int r = 0; r < 8; r++)
    begin
      pix_byte = image_mem[image * IMAGE_BYTES + (page * 8 + r) * ROW_BYTES + x / 8];
      col_bits[3'(r)] = pix_byte[3'(7 - x % 8)];
    end
    return col_bits;
  endfunction

  task automatic add_expected(input logic [1:0] cs, input logic di,
                              input glcd_pkg::byte_t data);
    if (exp_count < LOG_LEN)
      exp_log[exp_count] = {cs, di, data};
    exp_count++;
  endtask

  task automatic build_expected();
    int         image;
    logic [1:0] cs;
    exp_count = 0;
    add_expected(2'b11, 1'b0, `GLCD_CMD_ON);
    add_expected(2'b11, 1'b0, `GLCD_CMD_START_LINE);
    for (int p = 0; p < `GLCD_PAGES; p++)
    begin
      add_expected(2'b11, 1'b0, `GLCD_CMD_SET_PAGE + 8'(p));
      add_expected(2'b11, 1'b0, `GLCD_CMD_SET_Y);
      for (int c = 0; c < `GLCD_HALF_COLS; c++)
        add_expected(2'b11, 1'b1, 8'h00);  // Erase
    end
    for (int pass = 0; exp_count < LOG_LEN; pass++)
    begin
      image = pass % `GLCD_NUM_IMAGES;  // Wraps to image 0
      for (int p = 0; p < `GLCD_PAGES; p++)
      begin
        for (int h = 0; h < 2; h++)
        begin
          cs = (h == 0) ? 2'b01 : 2'b10;  // Left before right
          add_expected(cs, 1'b0, `GLCD_CMD_SET_PAGE + 8'(p));
          add_expected(cs, 1'b0, `GLCD_CMD_SET_Y);
          for (int c = 0; c < `GLCD_HALF_COLS; c++)
            add_expected(cs, 1'b1, model_column(image, p, h, c));
        end
      end
    end
  endtask

  task automatic load_images();
    for (int a = 0; a < STORE_BYTES; a++)
    begin
      @(negedge clk);
      load_en   = 1'b1;
      load_addr = glcd_pkg::store_addr_t'(a);
      load_data = image_mem[a];
    end
    @(negedge clk);
    load_en = 1'b0;
  endtask

  // Enable toggles on every rising clock edge out of reset
  always @(negedge clk)
  begin
    if (en_armed)
    begin
      assert (lcd_en != en_prev) else abort_run("lcd_en did not toggle on a clock edge");
    end
    en_prev  = lcd_en;
    en_armed = rst_n;
  end

  // Panel latches on the falling edge of lcd_en
  always @(negedge lcd_en)
  begin
    if (lcd_cs != 2'b00 && log_count < LOG_LEN)
    begin
      assert (run) else abort_run("panel transfer appeared before run was raised");
      assert (lcd_rw == 1'b0) else abort_run("lcd_rw was high during a transfer");
      assert ({lcd_cs, lcd_di, lcd_data} == exp_log[log_count])
      else value_error($sformatf("transfer_order[%0d]", log_count),
                       32'(exp_log[log_count]), 32'({lcd_cs, lcd_di, lcd_data}));
      bus_log.push_back({lcd_cs, lcd_di, lcd_data});
      log_count++;
    end
  end

  task automatic check_records(output int checked);
    int    count;
    int    base;
    int    idx;
    string name;
    checked = 0;
    for (int i = 0; i < num_recs; i++)
    begin
      name = $sformatf("%0s", rec_name[i]);
      if (rec_kind[i] == text_t'("cmd"))
      begin
        idx = int'(rec_arg[i]);
        if (idx >= LOG_LEN)
          abort_run("cmd record points past the end of the transfer log");
        assert (bus_log[idx] == xfer_t'(rec_exp[i]))
        else value_error(name, rec_exp[i], 32'(bus_log[idx]));
      end
      else if (rec_kind[i] == text_t'("count"))
      begin
        count = 0;
        for (int k = 2; k < LOG_LEN; k++)  // Init commands excluded
          if (bus_log[k][10:9] == rec_arg[i][1:0])
            count++;
        assert (count == int'(rec_exp[i])) else value_error(name, rec_exp[i], 32'(count));
      end
      else if (rec_kind[i] == text_t'("pixel"))
      begin
        idx = FIRST_SEND + int'(rec_arg[i][9:6]) * BLOCK_LEN + 2 + int'(rec_arg[i][5:0]);
        assert (bus_log[idx][7:0] == rec_exp[i][7:0])
        else value_error(name, rec_exp[i], 32'(bus_log[idx][7:0]));
      end
      else if (rec_kind[i] == text_t'("wrap"))
      begin
        base = FIRST_SEND + int'(rec_arg[i]) * PASS_LEN;
        if (base + BLOCK_LEN > LOG_LEN)
          abort_run("wrap record points past the end of the transfer log");
        count = 0;
        for (int k = 0; k < BLOCK_LEN; k++)
          if (bus_log[base + k] == bus_log[FIRST_SEND + k])
            count++;
        assert (count == int'(rec_exp[i])) else value_error(name, rec_exp[i], 32'(count));
      end
      else
      begin
        abort_run("unknown record kind in the tests file");
      end
      checked++;
    end
  endtask

  initial
  begin
    int checked;
    clk       = 1'b0;
    rst_n     = 1'b0;
    run       = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    log_count = 0;
    en_armed  = 1'b0;
    read_tests();
    build_images();
    plant_pixels();
    build_expected();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (lcd_cs == 2'b00 && lcd_di == 1'b0 && lcd_rw == 1'b0)
    else abort_run("panel bus was not quiet after reset");
    load_images();
    assert (log_count == 0) else abort_run("panel transfer appeared while run was low");
    @(negedge clk);
    run = 1'b1;  // Stays high from here on
    wait (log_count == LOG_LEN);
    check_records(checked);
    if (checked > 0 && checked == num_recs)
    begin
      $display("*** PASSED ***");
      $finish;
    end
    else
    begin
      $display("Failure: no test record was checked");
      $display("*** FAILED ***");
      $fatal(1, "no records");
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the panel did not finish %0d transfers in time", LOG_LEN);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

/* glcd_display.f */
+incdir+include
hdl/glcd_pkg.sv
hdl/frame_store.sv
hdl/block_transposer.sv
hdl/glcd_ctrl.sv
hdl/glcd_display.sv
sim/tb_glcd_display.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_glcd_display \
  -f glcd_display.f \
  -o Vtb_glcd_display

sim_out="$(./obj_dir/Vtb_glcd_display 2>&1)" || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qF -- '*** PASSED ***'; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* sim/glcd_tests.txt */
# name kind argument expected, argument and expected in hex
# cmd log index {cs,di,data}, count cs transfers, pixel {page,half,col} byte, wrap pass matches
display_on        cmd   0    63F
start_line        cmd   1    6C0
erase_page0       cmd   2    6B8
erase_y0          cmd   3    640
erase_first_byte  cmd   4    700
erase_page7       cmd   1D0  6BF
erase_last_byte   cmd   211  700
erase_count       count 3    210
left_count        count 1    462
right_count       count 2    420
img0_left_page0   cmd   212  2B8
img0_left_y0      cmd   213  240
img0_right_page0  cmd   254  4B8
img0_right_y0     cmd   255  440
img0_left_page1   cmd   296  2B9
img0_right_page7  cmd   5F0  4BF
img1_left_page0   cmd   632  2B8
wrap_left_page0   cmd   A52  2B8
pix_p0_l_c0       pixel 0    A5
pix_p0_l_c1       pixel 1    3C
pix_p2_r_c8       pixel 148  FF
pix_p3_r_c21      pixel 1D5  81
pix_p5_l_c40      pixel 2A8  00
pix_p7_r_c63      pixel 3FF  7E
wrap_image0       wrap  2    42
